// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fsync_remote_rf
FILELIST  = fsync_remote_rf.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^>>> PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// ==== fsync_remote_rf.f ====
hdl/fsync_cfg_pkg.sv
hdl/fsync_pipe_pkg.sv
hdl/fsync_sig_gen.sv
hdl/fsync_conflict_stage.sv
hdl/fsync_dm_rf.sv
hdl/fsync_remote_rf.sv
testbench/tb_fsync_remote_rf.sv

// ==== hdl/fsync_cfg_pkg.sv ====
// Fractal sync remote RF configuration
// Field widths, width typedefs and the per-level signature offset table
// used to flatten a (level, id) pair into a register index

`default_nettype none

package fsync_cfg_pkg;

  localparam int unsigned LEVEL_WIDTH    = 2;  // Synchronization level
  localparam int unsigned ID_WIDTH       = 3;  // Barrier id
  localparam int unsigned LOCAL_ID_WIDTH = 2;  // Id without its lowest bit
  localparam int unsigned SD_WIDTH       = 2;  // Back-routing mask
  localparam int unsigned N_REGS         = 10; // RF entries
  localparam int unsigned SIG_WIDTH      = 4;  // Flat register index
  localparam int unsigned SIG_LUT_WIDTH  = 5;  // Untruncated signature

  localparam int unsigned N_LEVELS = 2**LEVEL_WIDTH;

  typedef logic [LEVEL_WIDTH-1:0]    level_t;
  typedef logic [ID_WIDTH-1:0]       id_t;
  typedef logic [LOCAL_ID_WIDTH-1:0] local_id_t;
  typedef logic [SD_WIDTH-1:0]       sd_t;
  typedef logic [SIG_WIDTH-1:0]      sig_t;
  typedef logic [SIG_LUT_WIDTH-1:0]  sig_full_t;

  // First signature of each level, plus one sentinel entry that closes
  // the range of the highest level
  localparam sig_full_t SIG_OFFSET [N_LEVELS+1] = '{
    5'd0,  // One barrier on level 0
    5'd1,  // One barrier on level 1
    5'd2,  // Four barriers on level 2
    5'd6,  // Four barriers on level 3
    5'd10  // Sentinel
  };

endpackage : fsync_cfg_pkg

`default_nettype wire

// ==== hdl/fsync_conflict_stage.sv ====
// Fractal sync conflict stage
// Finds ports in the same cycle that target the same local id. The lower
// port is bypassed and carries the merged sd, the higher one is ignored.
// Gates the RF strobes accordingly and registers the result

`timescale 1ns/1ps
`default_nettype none

module fsync_conflict_stage #(
  parameter int unsigned N_PORTS = 2
) (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  input  fsync_pipe_pkg::sig_req_t sig_req_i [N_PORTS],
  output fsync_pipe_pkg::rf_req_t  rf_req_o  [N_PORTS]
);

  import fsync_cfg_pkg::*;
  import fsync_pipe_pkg::*;

  logic [N_PORTS-1:0] active;     // Port has check or set
  logic [N_PORTS-1:0] bypass;
  logic [N_PORTS-1:0] ignore;
  sd_t                sd_merged [N_PORTS];
  rf_req_t            rf_req_d  [N_PORTS];

  always_comb begin : active_calc
    for (int unsigned i = 0; i < N_PORTS; i++) begin
      active[i] = sig_req_i[i].check | sig_req_i[i].set;
    end
  end

  // Ports resolve in ascending order and pair with the first matching higher port
  always_comb begin : pair_resolve
    logic matched;
    bypass  = '0;
    ignore  = '0;
    matched = 1'b0;
    for (int unsigned i = 0; i < N_PORTS; i++) begin
      sd_merged[i] = sig_req_i[i].sd;
    end
    for (int unsigned i = 0; i + 1 < N_PORTS; i++) begin
      matched = 1'b0;
      if (active[i] && !ignore[i]) begin
        for (int unsigned j = i + 1; j < N_PORTS; j++) begin
          if (!matched && active[j] &&
              (sig_req_i[i].local_id == sig_req_i[j].local_id)) begin
            matched      = 1'b1;
            bypass[i]    = 1'b1;
            ignore[j]    = 1'b1;
            sd_merged[i] = sig_req_i[i].sd | sig_req_i[j].sd;  // Both destinations
          end
        end
      end
    end
  end

  always_comb begin : strobe_gate
    for (int unsigned i = 0; i < N_PORTS; i++) begin
      rf_req_d[i].sig       = sig_req_i[i].sig;
      rf_req_d[i].sig_valid = sig_req_i[i].sig_valid;
      rf_req_d[i].sd        = sd_merged[i];
      rf_req_d[i].check     = sig_req_i[i].check & ~(bypass[i] | ignore[i]);  // Pair answered locally
      rf_req_d[i].set       = sig_req_i[i].set & ~ignore[i];
      rf_req_d[i].bypass    = bypass[i];
      rf_req_d[i].ignore    = ignore[i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : stage_reg
    if (!rst_n_i) begin
      for (int unsigned i = 0; i < N_PORTS; i++) begin
        rf_req_o[i] <= '0;
      end
    end else begin
      for (int unsigned i = 0; i < N_PORTS; i++) begin
        rf_req_o[i] <= rf_req_d[i];
      end
    end
  end

endmodule : fsync_conflict_stage

`default_nettype wire

// ==== hdl/fsync_dm_rf.sv ====
// Fractal sync directly mapped barrier register file
// One entry per signature holding a present bit and an sd mask.
// Set and check requests are applied port by port in ascending order,
// and all response fields leave through one register

`timescale 1ns/1ps
`default_nettype none

module fsync_dm_rf #(
  parameter int unsigned N_PORTS = 2
) (
  input  wire                             clk_i,
  input  wire                             rst_n_i,
  input  fsync_pipe_pkg::rf_req_t   rf_req_i [N_PORTS],
  output fsync_pipe_pkg::port_rsp_t rsp_o    [N_PORTS]
);

  import fsync_cfg_pkg::*;
  import fsync_pipe_pkg::*;

  logic [N_REGS-1:0] present_q;    // Entry holds a pending barrier
  logic [N_REGS-1:0] present_d;
  sd_t               sd_q [N_REGS];  // Stored destinations
  sd_t               sd_d [N_REGS];
  port_rsp_t         rsp_d [N_PORTS];

  // Later ports see the updates of earlier ports in the same cycle
  always_comb begin : rf_update
    sig_t idx;
    idx       = '0;
    present_d = present_q;
    sd_d      = sd_q;
    for (int unsigned i = 0; i < N_PORTS; i++) begin
      idx              = rf_req_i[i].sig;
      rsp_d[i].present = 1'b0;
      rsp_d[i].sd      = '0;
      rsp_d[i].sig_err = ~rf_req_i[i].sig_valid;
      rsp_d[i].bypass  = rf_req_i[i].bypass;
      rsp_d[i].ignore  = rf_req_i[i].ignore;
      if (rf_req_i[i].sig_valid) begin  // Bad index leaves array alone
        if (rf_req_i[i].set) begin
          if (present_d[idx]) begin  // Partner already arrived
            rsp_d[i].present = 1'b1;
            rsp_d[i].sd      = sd_d[idx] | rf_req_i[i].sd;
            present_d[idx]   = 1'b0;
          end else begin  // Park the first arrival
            present_d[idx] = 1'b1;
            sd_d[idx]      = rf_req_i[i].sd;
          end
        end else if (rf_req_i[i].check) begin
          if (present_d[idx]) begin
            rsp_d[i].present = 1'b1;
            rsp_d[i].sd      = sd_d[idx];
            present_d[idx]   = 1'b0;  // Consumed by the check
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : present_reg
    if (!rst_n_i) begin
      present_q <= '0;
    end else begin
      present_q <= present_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : sd_reg
    if (!rst_n_i) begin
      for (int unsigned r = 0; r < N_REGS; r++) begin
        sd_q[r] <= '0;
      end
    end else begin
      sd_q <= sd_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : rsp_reg
    if (!rst_n_i) begin
      for (int unsigned i = 0; i < N_PORTS; i++) begin
        rsp_o[i] <= '0;
      end
    end else begin
      for (int unsigned i = 0; i < N_PORTS; i++) begin
        rsp_o[i] <= rsp_d[i];
      end
    end
  end

endmodule : fsync_dm_rf

`default_nettype wire

// ==== hdl/fsync_pipe_pkg.sv ====
// Fractal sync remote RF pipeline payloads
// Packed structs carrying one port's request and response between the
// signature, conflict and register stages

`default_nettype none

package fsync_pipe_pkg;

  import fsync_cfg_pkg::*;

  // External request of one port
  typedef struct packed {
    level_t level;  // Synchronization level
    id_t    id;     // Barrier id
    sd_t    sd;     // Source/destination mask
    logic   check;  // Check RF for a response
    logic   set;    // Set RF with a request
  } port_req_t;

  // Signature stage output
  typedef struct packed {
    local_id_t local_id;   // For duplicate detection
    sig_t      sig;        // Flat RF index
    logic      sig_valid;  // Index inside level range
    sd_t       sd;
    logic      check;
    logic      set;
  } sig_req_t;

  // Conflict stage output, strobes already gated
  typedef struct packed {
    sig_t sig;
    logic sig_valid;
    sd_t  sd;      // Merged mask on a bypassed port
    logic check;
    logic set;
    logic bypass;  // Lower port of a same-cycle pair
    logic ignore;  // Higher port of a same-cycle pair
  } rf_req_t;

  // External response of one port
  typedef struct packed {
    logic present;  // Entry found in RF
    sd_t  sd;       // Back-routing destinations
    logic sig_err;  // Signature out of range
    logic bypass;
    logic ignore;
  } port_rsp_t;

endpackage : fsync_pipe_pkg

`default_nettype wire

// ==== hdl/fsync_remote_rf.sv ====
// Fractal sync remote register file, top level
// Chains signature generation, same-cycle conflict resolution with a
// stage register, and the directly mapped RF with registered
// responses. Fixed latency of two cycles

`timescale 1ns/1ps
`default_nettype none

module fsync_remote_rf #(
  parameter int unsigned N_PORTS = 2
) (
  input  wire                             clk_i,
  input  wire                             rst_n_i,
  input  fsync_pipe_pkg::port_req_t req_i [N_PORTS],
  output fsync_pipe_pkg::port_rsp_t rsp_o [N_PORTS]
);

  import fsync_pipe_pkg::*;

  sig_req_t sig_req [N_PORTS];  // Stage 1 to 2, combinational
  rf_req_t  rf_req  [N_PORTS];  // Stage 2 to 3, registered

  fsync_sig_gen #(
    .N_PORTS   ( N_PORTS )
  ) u_sig_gen (
    .req_i     ( req_i   ),
    .sig_req_o ( sig_req )
  );

  fsync_conflict_stage #(
    .N_PORTS   ( N_PORTS )
  ) u_conflict (
    .clk_i     ( clk_i   ),
    .rst_n_i   ( rst_n_i ),
    .sig_req_i ( sig_req ),
    .rf_req_o  ( rf_req  )
  );

  fsync_dm_rf #(
    .N_PORTS  ( N_PORTS )
  ) u_dm_rf (
    .clk_i    ( clk_i   ),
    .rst_n_i  ( rst_n_i ),
    .rf_req_i ( rf_req  ),
    .rsp_o    ( rsp_o   )
  );

endmodule : fsync_remote_rf

`default_nettype wire

// ==== hdl/fsync_sig_gen.sv ====
// Fractal sync signature generator
// Maps each port's level and id to a flat RF index through the level
// offset table and flags indices outside the range of their level.
// Purely combinational

`timescale 1ns/1ps
`default_nettype none

module fsync_sig_gen #(
  parameter int unsigned N_PORTS = 2
) (
  input  fsync_pipe_pkg::port_req_t req_i     [N_PORTS],
  output fsync_pipe_pkg::sig_req_t  sig_req_o [N_PORTS]
);

  import fsync_cfg_pkg::*;
  import fsync_pipe_pkg::*;

  local_id_t local_id  [N_PORTS];
  sig_full_t sig_full  [N_PORTS];  // Before truncation
  sig_full_t sig_limit [N_PORTS];  // First index of next level

  always_comb begin : sig_calc
    for (int unsigned i = 0; i < N_PORTS; i++) begin
      local_id[i]  = req_i[i].id[ID_WIDTH-1:1];  // Drop pairing bit
      sig_full[i]  = SIG_OFFSET[req_i[i].level] + sig_full_t'(local_id[i]);
      sig_limit[i] = SIG_OFFSET[int'(req_i[i].level) + 1];
    end
  end

  always_comb begin : sig_pack
    for (int unsigned i = 0; i < N_PORTS; i++) begin
      sig_req_o[i].local_id  = local_id[i];
      sig_req_o[i].sig       = sig_t'(sig_full[i]);
      // Must fit in RF and stay within own level
      sig_req_o[i].sig_valid = (sig_full[i] < sig_full_t'(N_REGS)) &&
                               (sig_full[i] < sig_limit[i]);
      sig_req_o[i].sd        = req_i[i].sd;
      sig_req_o[i].check     = req_i[i].check;
      sig_req_o[i].set       = req_i[i].set;
    end
  end

endmodule : fsync_sig_gen

`default_nettype wire

// ==== testbench/fsync_tests.txt ====
# Columns: p0 level id sd check set, p1 level id sd check set, then expected
# p0 present sd sig_err bypass ignore, p1 present sd sig_err bypass ignore
0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0
2 2 1 0 1  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0
0 0 0 0 0  2 3 2 0 1  0 0 0 0 0  1 3 0 0 0
2 2 0 1 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0
3 0 2 0 1  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0
0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0
0 0 0 0 0  3 1 0 1 0  0 0 0 0 0  1 2 0 0 0
0 2 3 0 1  0 0 0 0 0  0 0 1 0 0  0 0 0 0 0
0 0 0 0 0  1 0 0 1 0  0 0 0 0 0  0 0 0 0 0
3 4 1 0 1  3 5 2 0 1  0 0 0 1 0  0 0 0 0 1
3 4 0 1 0  0 0 0 0 0  1 3 0 0 0  0 0 0 0 0
2 4 1 0 1  2 6 2 0 1  0 0 0 0 0  0 0 0 0 0
2 5 2 0 1  2 7 1 0 1  1 3 0 0 0  1 3 0 0 0
2 4 0 1 0  3 2 1 0 1  0 0 0 0 0  0 0 0 0 0
3 3 0 1 0  0 0 0 0 0  1 1 0 0 0  0 0 0 0 0
0 0 0 0 0  1 2 1 0 1  0 0 0 0 0  0 0 1 0 0
2 0 0 1 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0
0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0

// ==== testbench/tb_fsync_remote_rf.sv ====
// Testbench for the fractal sync remote register file
// Reads request vectors and expected responses from a text file, drives
// both ports after each rising edge and checks every response field
// two edges after the request was driven

`timescale 1ns/1ps
`default_nettype none

module tb_fsync_remote_rf;

  import fsync_cfg_pkg::*;
  import fsync_pipe_pkg::*;

  localparam int unsigned N_PORTS   = 2;
  localparam int          LATENCY   = 2;  // Edges from drive to compare
  localparam string       TEST_FILE = "testbench/fsync_tests.txt";

  typedef struct packed {
    port_req_t p1;
    port_req_t p0;
  } req_pair_t;

  typedef struct packed {
    port_rsp_t p1;
    port_rsp_t p0;
  } rsp_pair_t;

  logic      clk_i;
  logic      rst_n_i;
  port_req_t req [N_PORTS];
  port_rsp_t rsp [N_PORTS];

  req_pair_t vec_req_q [$];  // Whole file
  rsp_pair_t vec_exp_q [$];
  rsp_pair_t pending_q [$];  // Requests in flight
  int        err_cnt     = 0;
  int        check_cnt   = 0;
  int        cycle_cnt   = 0;
  int        cycle_limit = 10;  // Raised once the file is read

  fsync_remote_rf #(
    .N_PORTS ( N_PORTS )
  ) u_fsync_remote_rf (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .req_i   ( req     ),
    .rsp_o   ( rsp     )
  );

  always #20 clk_i = ~clk_i;  // 40 ns period

  always @(posedge clk_i) begin : watchdog
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run exceeded %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic drive_idle();
    for (int i = 0; i < N_PORTS; i++) begin
      req[i] = '0;
    end
  endtask

  task automatic load_vectors(output bit ok);
    int        fd;
    int        n;
    string     line;
    int        v [20];
    req_pair_t rq;
    rsp_pair_t rs;
    fd = $fopen(TEST_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#") begin  // Skip column notes
          n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                      v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19]);
          if (n == 20) begin
            rq.p0 = '{level_t'(v[0]), id_t'(v[1]), sd_t'(v[2]), v[3][0], v[4][0]};
            rq.p1 = '{level_t'(v[5]), id_t'(v[6]), sd_t'(v[7]), v[8][0], v[9][0]};
            rs.p0 = '{v[10][0], sd_t'(v[11]), v[12][0], v[13][0], v[14][0]};
            rs.p1 = '{v[15][0], sd_t'(v[16]), v[17][0], v[18][0], v[19][0]};
            vec_req_q.push_back(rq);
            vec_exp_q.push_back(rs);
          end
        end
      end
      $fclose(fd);
    end
    ok = (vec_req_q.size() > 0);
  endtask

  task automatic check_field(input int port, input string name,
                             input logic [7:0] got, input logic [7:0] exp);
    check_cnt = check_cnt + 1;
    assert (got === exp) else begin
      err_cnt = err_cnt + 1;
      $display("Mismatch at %0t: port %0d field %s got %0d expected %0d",
               $time, port, name, got, exp);
    end
  endtask

  task automatic check_port(input int port, input port_rsp_t got, input port_rsp_t exp);
    check_field(port, "present", 8'(got.present), 8'(exp.present));
    check_field(port, "sd",      8'(got.sd),      8'(exp.sd));
    check_field(port, "sig_err", 8'(got.sig_err), 8'(exp.sig_err));
    check_field(port, "bypass",  8'(got.bypass),  8'(exp.bypass));
    check_field(port, "ignore",  8'(got.ignore),  8'(exp.ignore));
  endtask

  task automatic compare_oldest();
    rsp_pair_t exp;
    exp = pending_q.pop_front();
    check_port(0, rsp[0], exp.p0);
    check_port(1, rsp[1], exp.p1);
  endtask

  initial begin : main
    bit ok;
    clk_i   = 1'b0;
    rst_n_i = 1'b0;
    drive_idle();
    load_vectors(ok);
    if (!ok) begin
      $display("Error: data file %s is missing or holds no vectors", TEST_FILE);
      $display(">>> FAIL");
      $finish;
    end else begin
      cycle_limit = vec_req_q.size() + 10;
      repeat (2) @(posedge clk_i);  // Reset for 2 cycles
      #2;
      rst_n_i = 1'b1;
      foreach (vec_req_q[i]) begin
        @(posedge clk_i);
        #2;
        if (pending_q.size() == LATENCY) begin
          compare_oldest();
        end
        req[0] = vec_req_q[i].p0;
        req[1] = vec_req_q[i].p1;
        pending_q.push_back(vec_exp_q[i]);
      end
      while (pending_q.size() > 0) begin  // Drain the pipeline
        @(posedge clk_i);
        #2;
        drive_idle();
        compare_oldest();
      end
      $display("Checks: %0d, mismatches: %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

endmodule : tb_fsync_remote_rf

`default_nettype wire
